//--- rv_pipe_top.f
+incdir+verification
source/rv_pkg.sv
source/fetch_if.sv
source/pc_counter.sv
source/fetch_ctrl.sv
source/decode_stage.sv
source/regfile.sv
source/alu.sv
source/execute_stage.sv
source/rv_pipe_top.sv
verification/rv_pipe_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := rv_pipe_tb
FILELIST  := rv_pipe_top.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)

SRCS := $(wildcard source/*.sv) $(wildcard verification/*.sv) $(wildcard verification/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

//--- verification/rv_model.svh
`ifndef RV_MODEL_SVH
`define RV_MODEL_SVH

// ------------------------------------------------------------
// random program builder
// ------------------------------------------------------------
// registers kept to x0..x7 so dependencies are frequent
task automatic build_program();
    logic [31:0] r;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [31:0] off;
    int          t;
    for (int i = 0; i < PROG_LEN - 1; i++) begin
        r   = rand32();
        rd  = {2'b00, r[10:8]};
        rs1 = {2'b00, r[13:11]};
        rs2 = {2'b00, r[16:14]};
        f3  = r[19:17];
        t   = i + 1 + (r[31:24] % (PROG_LEN - 1 - i));  // forward only
        off = (t - i) * 4;
        case (r[2:0])
            3'd0, 3'd1: prog[i] = {1'b0, r[20] && (f3 == 3'd0 || f3 == 3'd5), 5'b0,
                                   rs2, rs1, f3, rd, 7'h33};
            3'd2, 3'd3: begin
                if (f3 == 3'd1)
                    prog[i] = {7'b0, r[24:20], rs1, f3, rd, 7'h13};
                else if (f3 == 3'd5)
                    prog[i] = {1'b0, r[25], 5'b0, r[24:20], rs1, f3, rd, 7'h13};
                else
                    prog[i] = {r[31:20], rs1, f3, rd, 7'h13};
            end
            3'd4: prog[i] = {r[31:12], rd, 7'h37};     // lui
            3'd5: prog[i] = {r[31:12], rd, 7'h17};     // auipc
            3'd6: begin
                if (f3 == 3'd2) f3 = 3'd0;             // no branch codes 2, 3
                if (f3 == 3'd3) f3 = 3'd1;
                prog[i] = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
            end
            default: prog[i] = {off[20], off[10:1], off[11], off[19:12], rd, 7'h6F};
        endcase
    end
    prog[PROG_LEN-1] = 32'h0000_006F;   // jal x0, 0 parks the core
endtask

// ------------------------------------------------------------
// instruction level reference
// ------------------------------------------------------------
function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
    case (f3)
        3'd0:    return alt ? a - b : a + b;
        3'd1:    return a << b[4:0];
        3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'd3:    return (a < b) ? 32'd1 : 32'd0;
        3'd4:    return a ^ b;
        3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'd6:    return a | b;
        default: return a & b;
    endcase
endfunction

function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
                                    input logic [31:0] b);
    case (f3)
        3'd0:    return a == b;
        3'd1:    return a != b;
        3'd4:    return $signed(a) < $signed(b);
        3'd5:    return $signed(a) >= $signed(b);
        3'd6:    return a < b;
        default: return a >= b;
    endcase
endfunction

// walks the program and queues every expected retirement
task automatic run_model();
    logic [31:0] regs [32];
    logic [31:0] pc;
    logic [31:0] nxt;
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] val;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic        wr;
    exp_pc_q.delete();
    exp_rd_q.delete();
    exp_data_q.delete();
    for (int k = 0; k < 32; k++) regs[k] = '0;
    pc = 32'h0;
    for (int n = 0; n < PROG_LEN; n++) begin
        ins = prog[pc[7:2]];
        f3  = ins[14:12];
        rd  = ins[11:7];
        a   = regs[ins[19:15]];
        b   = regs[ins[24:20]];
        nxt = pc + 4;
        wr  = 1'b0;
        val = '0;
        case (ins[6:0])
            7'h33: begin wr = 1'b1; val = alu_ref(f3, ins[30], a, b); end
            7'h13: begin
                wr  = 1'b1;
                val = alu_ref(f3, ins[30] && (f3 == 3'd5), a, {{20{ins[31]}}, ins[31:20]});
            end
            7'h37: begin wr = 1'b1; val = {ins[31:12], 12'b0}; end
            7'h17: begin wr = 1'b1; val = pc + {ins[31:12], 12'b0}; end
            7'h63: if (branch_ref(f3, a, b))
                nxt = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            7'h6F: begin
                wr  = 1'b1;
                val = pc + 4;
                nxt = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            default: ;
        endcase
        if (rd == 5'd0) wr = 1'b0;   // x0 writes vanish
        exp_pc_q.push_back(pc);
        exp_rd_q.push_back(wr ? rd : 5'd0);
        exp_data_q.push_back(wr ? val : 32'd0);
        if (wr) regs[rd] = val;
        if (pc == (PROG_LEN - 1) * 4) break;
        pc = nxt;
    end
endtask

`endif

//--- verification/rv_pipe_tb.sv
`timescale 1ns/1ns

module rv_pipe_tb;

    localparam int          PROGS       = 8;
    localparam int          PROG_LEN    = 48;
    localparam int          CYCLE_LIMIT = PROGS * PROG_LEN * 20;
    localparam logic [31:0] BOOT_PC     = 32'h0000_0000;       // first fetch after reset
    localparam logic [31:0] PARK_PC     = (PROG_LEN - 1) * 4;  // closing jal to itself

    logic        clk = 1'b0;
    logic        rst_n = 1'b0;
    logic        imem_ready_i = 1'b0;
    logic [31:0] imem_rdata_i;
    logic        imem_valid_o;
    logic [31:0] imem_addr_o;
    logic        retire_valid_o;
    logic [31:0] retire_pc_o;
    logic [4:0]  retire_rd_o;
    logic [31:0] retire_data_o;

    logic [31:0] prog [PROG_LEN];
    logic [31:0] exp_pc_q[$];
    logic [4:0]  exp_rd_q[$];
    logic [31:0] exp_data_q[$];
    logic [31:0] rng = 32'd96438;        // program stream
    logic [31:0] ready_rng = 32'd96438;  // back-pressure stream
    logic        first_fetch = 1'b1;     // no request seen since reset
    int          cycles = 0;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand32();
        rng = xorshift(rng);
        return rng;
    endfunction

    `include "rv_model.svh"

    rv_pipe_top dut0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .imem_valid_o   (imem_valid_o),
        .imem_addr_o    (imem_addr_o),
        .imem_ready_i   (imem_ready_i),
        .imem_rdata_i   (imem_rdata_i),
        .retire_valid_o (retire_valid_o),
        .retire_pc_o    (retire_pc_o),
        .retire_rd_o    (retire_rd_o),
        .retire_data_o  (retire_data_o)
    );

    always #10 clk = ~clk;

    // combinational instruction memory
    // past the program the word is a no-op built from the address
    assign imem_rdata_i = (imem_addr_o < PROG_LEN * 4) ? prog[imem_addr_o[7:2]]
                                                       : {imem_addr_o[31:2], 2'b00};

    always @(posedge clk) begin
        ready_rng    = xorshift(ready_rng);
        imem_ready_i <= (ready_rng % 10) < 6;   // about 60 percent
    end

    // ------------------------------------------------------------
    // retire checker
    // ------------------------------------------------------------
    always @(posedge clk) begin
        if (!rst_n) begin
            first_fetch = 1'b1;
            assert (!retire_valid_o && !imem_valid_o) else begin
                $display("FAIL %0t: retire_valid_o %b imem_valid_o %b during reset",
                         $time, retire_valid_o, imem_valid_o);
                $display("Result: FAILED");
                $fatal(1, "core active in reset");
            end
        end else begin
            if (imem_valid_o && first_fetch) begin
                first_fetch = 1'b0;
                assert (imem_addr_o == BOOT_PC) else begin
                    $display("FAIL %0t: first fetch from %h, expected %h",
                             $time, imem_addr_o, BOOT_PC);
                    $display("Result: FAILED");
                    $fatal(1, "wrong boot address");
                end
            end
            if (retire_valid_o && exp_pc_q.size() != 0) begin
                assert (retire_pc_o == exp_pc_q[0] && retire_rd_o == exp_rd_q[0] &&
                        retire_data_o == exp_data_q[0]) else begin
                    $display("FAIL %0t: retire pc %h rd %0d data %h, expected pc %h rd %0d data %h",
                             $time, retire_pc_o, retire_rd_o, retire_data_o,
                             exp_pc_q[0], exp_rd_q[0], exp_data_q[0]);
                    $display("Result: FAILED");
                    $fatal(1, "retirement mismatch");
                end
                void'(exp_pc_q.pop_front());
                void'(exp_rd_q.pop_front());
                void'(exp_data_q.pop_front());
            end else if (retire_valid_o) begin
                // queue drained so only the parked jal keeps retiring
                assert (retire_pc_o == PARK_PC && retire_rd_o == 5'd0 &&
                        retire_data_o == 32'd0) else begin
                    $display("FAIL %0t: retire pc %h rd %0d data %h after the program end",
                             $time, retire_pc_o, retire_rd_o, retire_data_o);
                    $display("Result: FAILED");
                    $fatal(1, "retirement past the parked jal");
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, expected retirements never arrived", cycles);
            $display("Result: FAILED");
            $fatal(1, "timeout");
        end
    end

    // ------------------------------------------------------------
    // program sequence
    // ------------------------------------------------------------
    initial begin
        for (int p = 0; p < PROGS; p++) begin
            @(posedge clk);
            rst_n <= 1'b0;
            @(posedge clk);            // memory swapped while the core sits in reset
            build_program();
            run_model();
            @(posedge clk);
            rst_n <= 1'b1;             // two cycles of reset
            while (exp_pc_q.size() != 0) @(negedge clk);   // checker done by the falling edge
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule

//--- source/rv_pipe_top.sv
`timescale 1ns/1ns

module rv_pipe_top (
    input  logic              clk,
    input  logic              rst_n,
    // instruction port
    output logic              imem_valid_o,
    output rv_pkg::word_t     imem_addr_o,
    input  logic              imem_ready_i,
    input  rv_pkg::word_t     imem_rdata_i,
    // retire trace
    output logic              retire_valid_o,
    output rv_pkg::word_t     retire_pc_o,
    output rv_pkg::reg_addr_t retire_rd_o,
    output rv_pkg::word_t     retire_data_o
);

    rv_pkg::word_t    pc;
    logic             advance;
    logic             redirect_valid;
    rv_pkg::word_t    redirect_pc;
    logic             dec_valid;
    logic             dec_ready;
    rv_pkg::decoded_t dec_data;

    fetch_if fetch_bus ();

    pc_counter pc_u0 (
        .clk              (clk),
        .rst_n            (rst_n),
        .advance_i        (advance),
        .redirect_valid_i (redirect_valid),
        .redirect_pc_i    (redirect_pc),
        .pc_o             (pc)
    );

    fetch_ctrl fetch_u0 (
        .clk              (clk),
        .rst_n            (rst_n),
        .pc_i             (pc),
        .advance_o        (advance),
        .imem_valid_o     (imem_valid_o),
        .imem_addr_o      (imem_addr_o),
        .imem_ready_i     (imem_ready_i),
        .imem_rdata_i     (imem_rdata_i),
        .redirect_valid_i (redirect_valid),
        .fetch            (fetch_bus)
    );

    decode_stage decode_u0 (
        .clk              (clk),
        .rst_n            (rst_n),
        .fetch            (fetch_bus),
        .redirect_valid_i (redirect_valid),
        .dec_valid_o      (dec_valid),
        .dec_ready_i      (dec_ready),
        .dec_data_o       (dec_data)
    );

    execute_stage execute_u0 (
        .clk              (clk),
        .rst_n            (rst_n),
        .dec_valid_i      (dec_valid),
        .dec_ready_o      (dec_ready),
        .dec_data_i       (dec_data),
        .redirect_valid_o (redirect_valid),
        .redirect_pc_o    (redirect_pc),
        .retire_valid_o   (retire_valid_o),
        .retire_pc_o      (retire_pc_o),
        .retire_rd_o      (retire_rd_o),
        .retire_data_o    (retire_data_o)
    );

endmodule

//--- source/execute_stage.sv
`timescale 1ns/1ns

module execute_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              dec_valid_i,
    output logic              dec_ready_o,
    input  rv_pkg::decoded_t  dec_data_i,
    output logic              redirect_valid_o,
    output rv_pkg::word_t     redirect_pc_o,
    output logic              retire_valid_o,
    output rv_pkg::word_t     retire_pc_o,
    output rv_pkg::reg_addr_t retire_rd_o,
    output rv_pkg::word_t     retire_data_o
);

    // ID/EX
    logic              idex_valid_q;
    rv_pkg::decoded_t  idex_q;
    rv_pkg::word_t     idex_rs1_q;
    rv_pkg::word_t     idex_rs2_q;
    // EX/WB
    logic              exwb_valid_q;
    logic              exwb_taken_q;
    rv_pkg::word_t     exwb_pc_q;
    rv_pkg::word_t     exwb_target_q;
    rv_pkg::word_t     exwb_data_q;
    rv_pkg::reg_addr_t exwb_rd_q;     // zero when nothing written

    rv_pkg::word_t     rf_rd1;
    rv_pkg::word_t     rf_rd2;
    rv_pkg::word_t     rs1_val;
    rv_pkg::word_t     rs2_val;
    rv_pkg::word_t     alu_a;
    rv_pkg::word_t     alu_b;
    rv_pkg::word_t     alu_result;
    rv_pkg::word_t     wb_value;
    logic              alu_zero;
    logic              alu_neg;
    logic              alu_ovf;
    logic              alu_carry;
    logic              hazard;
    logic              take_dec;
    logic              cond_met;
    logic              taken;

    // ------------------------------------------------------------
    // operand read, forwarding and hazard
    // ------------------------------------------------------------
    regfile rf_u0 (
        .clk   (clk),
        .rst_n (rst_n),
        .rs1_i (dec_data_i.rs1),
        .rs2_i (dec_data_i.rs2),
        .rd1_o (rf_rd1),
        .rd2_o (rf_rd2),
        .we_i  (exwb_valid_q),
        .wa_i  (exwb_rd_q),
        .wd_i  (exwb_data_q)
    );

    // EX/WB result not in the file until the edge
    assign rs1_val = (exwb_valid_q && (exwb_rd_q != '0) && (exwb_rd_q == dec_data_i.rs1)) ?
                     exwb_data_q : rf_rd1;
    assign rs2_val = (exwb_valid_q && (exwb_rd_q != '0) && (exwb_rd_q == dec_data_i.rs2)) ?
                     exwb_data_q : rf_rd2;

    // ID/EX result not ready yet, bubble once
    assign hazard = dec_valid_i && idex_valid_q && (idex_q.rd != '0) &&
                    ((dec_data_i.rs1_used && (dec_data_i.rs1 == idex_q.rd)) ||
                     (dec_data_i.rs2_used && (dec_data_i.rs2 == idex_q.rd)));
    assign dec_ready_o = !hazard;
    assign take_dec    = dec_valid_i && dec_ready_o;

    // ------------------------------------------------------------
    // execute
    // ------------------------------------------------------------
    assign alu_a = idex_q.use_pc  ? idex_q.pc  : idex_rs1_q;
    assign alu_b = idex_q.use_imm ? idex_q.imm : idex_rs2_q;

    alu alu_u0 (
        .op_i       (idex_q.alu_op),
        .a_i        (alu_a),
        .b_i        (alu_b),
        .result_o   (alu_result),
        .zero_o     (alu_zero),
        .negative_o (alu_neg),
        .overflow_o (alu_ovf),
        .carry_o    (alu_carry)
    );

    always_comb begin
        case (idex_q.branch_cond)
            rv_pkg::BEQ:  cond_met = alu_zero;
            rv_pkg::BNE:  cond_met = !alu_zero;
            rv_pkg::BLT:  cond_met = alu_neg ^ alu_ovf;
            rv_pkg::BGE:  cond_met = !(alu_neg ^ alu_ovf);
            rv_pkg::BLTU: cond_met = !alu_carry;
            rv_pkg::BGEU: cond_met = alu_carry;
            default:      cond_met = 1'b0;
        endcase
    end

    assign taken    = idex_q.is_jump || (idex_q.is_branch && cond_met);
    assign wb_value = idex_q.is_jump ? idex_q.pc + rv_pkg::PC_STEP : alu_result; // jal link

    // ------------------------------------------------------------
    // pipeline registers
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idex_valid_q <= 1'b0;
            exwb_valid_q <= 1'b0;
        end else begin
            idex_valid_q <= take_dec && !redirect_valid_o;      // squash younger
            exwb_valid_q <= idex_valid_q && !redirect_valid_o;
        end
    end

    always_ff @(posedge clk) begin
        if (take_dec) begin
            idex_q     <= dec_data_i;
            idex_rs1_q <= rs1_val;
            idex_rs2_q <= rs2_val;
        end
        if (idex_valid_q) begin
            exwb_pc_q     <= idex_q.pc;
            exwb_rd_q     <= idex_q.rd;
            exwb_data_q   <= (idex_q.rd_we && (idex_q.rd != '0)) ? wb_value : '0;
            exwb_taken_q  <= taken;
            exwb_target_q <= idex_q.pc + idex_q.imm;   // branch and jal target
        end
    end

    // redirect and retire straight from EX/WB
    assign redirect_valid_o = exwb_valid_q && exwb_taken_q;
    assign redirect_pc_o    = exwb_target_q;
    assign retire_valid_o   = exwb_valid_q;
    assign retire_pc_o      = exwb_pc_q;
    assign retire_rd_o      = exwb_rd_q;
    assign retire_data_o    = exwb_data_q;

endmodule

//--- source/alu.sv
`timescale 1ns/1ns

module alu (
    input  rv_pkg::alu_op_e op_i,
    input  rv_pkg::word_t   a_i,
    input  rv_pkg::word_t   b_i,
    output rv_pkg::word_t   result_o,
    output logic            zero_o,
    output logic            negative_o,
    output logic            overflow_o,
    output logic            carry_o       // set means no borrow on sub
);

    logic                  subtract;
    rv_pkg::word_t         b_add;
    logic [rv_pkg::XLEN:0] sum;
    logic [4:0]            shamt;

    // one adder for add, sub and the compares
    assign subtract = (op_i != rv_pkg::ADD);
    assign b_add    = subtract ? ~b_i : b_i;
    assign sum      = {1'b0, a_i} + {1'b0, b_add} + {{rv_pkg::XLEN{1'b0}}, subtract};
    assign shamt    = b_i[4:0];

    // flags describe the adder
    assign carry_o    = sum[rv_pkg::XLEN];
    assign negative_o = sum[rv_pkg::XLEN-1];
    assign zero_o     = (sum[rv_pkg::XLEN-1:0] == '0);
    assign overflow_o = (a_i[rv_pkg::XLEN-1] == b_add[rv_pkg::XLEN-1]) &&
                        (sum[rv_pkg::XLEN-1] != a_i[rv_pkg::XLEN-1]);

    always_comb begin
        case (op_i)
            rv_pkg::ADD,
            rv_pkg::SUB:  result_o = sum[rv_pkg::XLEN-1:0];
            rv_pkg::SLL:  result_o = a_i << shamt;
            rv_pkg::SLT:  result_o = {{(rv_pkg::XLEN-1){1'b0}}, negative_o ^ overflow_o};
            rv_pkg::SLTU: result_o = {{(rv_pkg::XLEN-1){1'b0}}, !carry_o};
            rv_pkg::XOR:  result_o = a_i ^ b_i;
            rv_pkg::SRL:  result_o = a_i >> shamt;
            rv_pkg::SRA:  result_o = rv_pkg::word_t'($signed(a_i) >>> shamt);
            rv_pkg::OR:   result_o = a_i | b_i;
            rv_pkg::AND:  result_o = a_i & b_i;
            default:      result_o = '0;
        endcase
    end

endmodule

//--- source/regfile.sv
`timescale 1ns/1ns

module regfile (
    input  logic              clk,
    input  logic              rst_n,
    input  rv_pkg::reg_addr_t rs1_i,
    input  rv_pkg::reg_addr_t rs2_i,
    output rv_pkg::word_t     rd1_o,
    output rv_pkg::word_t     rd2_o,
    input  logic              we_i,
    input  rv_pkg::reg_addr_t wa_i,
    input  rv_pkg::word_t     wd_i
);

    rv_pkg::word_t regs [rv_pkg::NUM_REGS];

    // async read, x0 never written so it stays zero
    assign rd1_o = regs[rs1_i];
    assign rd2_o = regs[rs2_i];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < rv_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (wa_i != '0)) begin
            regs[wa_i] <= wd_i;
        end
    end

endmodule

//--- source/decode_stage.sv
`timescale 1ns/1ns

module decode_stage (
    input  logic             clk,
    input  logic             rst_n,
    fetch_if.consumer        fetch,
    input  logic             redirect_valid_i,
    output logic             dec_valid_o,
    input  logic             dec_ready_i,
    output rv_pkg::decoded_t dec_data_o
);

    rv_pkg::decoded_t dec_d;
    rv_pkg::word_t    instr;
    rv_pkg::word_t    imm_i;
    rv_pkg::word_t    imm_u;
    rv_pkg::word_t    imm_b;
    rv_pkg::word_t    imm_j;
    logic [2:0]       funct3;
    logic             alt;     // instr[30] picks sub / sra

    // funct3 plus alt bit to alu op
    function automatic rv_pkg::alu_op_e alu_map(input logic [2:0] f3, input logic alt_i);
        case (f3)
            3'b000:  alu_map = alt_i ? rv_pkg::SUB : rv_pkg::ADD;
            3'b001:  alu_map = rv_pkg::SLL;
            3'b010:  alu_map = rv_pkg::SLT;
            3'b011:  alu_map = rv_pkg::SLTU;
            3'b100:  alu_map = rv_pkg::XOR;
            3'b101:  alu_map = alt_i ? rv_pkg::SRA : rv_pkg::SRL;
            3'b110:  alu_map = rv_pkg::OR;
            default: alu_map = rv_pkg::AND;
        endcase
    endfunction

    assign instr  = fetch.instr;
    assign funct3 = instr[14:12];
    assign alt    = instr[30];

    // ------------------------------------------------------------
    // immediates
    // ------------------------------------------------------------
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    assign fetch.ready = !dec_valid_o || dec_ready_i;   // empty or draining

    always_comb begin
        dec_d             = '0;          // no-op unless matched below
        dec_d.pc          = fetch.pc;
        dec_d.rd          = instr[11:7];
        dec_d.rs1         = instr[19:15];
        dec_d.rs2         = instr[24:20];
        dec_d.alu_op      = rv_pkg::ADD;
        dec_d.branch_cond = rv_pkg::branch_e'(funct3);
        if (instr[1:0] == 2'b11) begin
            case (rv_pkg::opcode_e'(instr[6:2]))
                rv_pkg::OP: begin
                    dec_d.rs1_used = 1'b1;
                    dec_d.rs2_used = 1'b1;
                    dec_d.rd_we    = 1'b1;
                    dec_d.alu_op   = alu_map(funct3, alt);
                end
                rv_pkg::OP_IMM: begin
                    dec_d.rs1_used = 1'b1;
                    dec_d.rd_we    = 1'b1;
                    dec_d.use_imm  = 1'b1;
                    dec_d.imm      = imm_i;
                    dec_d.alu_op   = alu_map(funct3, alt && (funct3 == 3'b101)); // addi has no sub
                end
                rv_pkg::LUI: begin
                    dec_d.rd_we   = 1'b1;        // x0 + imm
                    dec_d.use_imm = 1'b1;
                    dec_d.imm     = imm_u;
                end
                rv_pkg::AUIPC: begin
                    dec_d.rd_we   = 1'b1;
                    dec_d.use_pc  = 1'b1;
                    dec_d.use_imm = 1'b1;
                    dec_d.imm     = imm_u;
                end
                rv_pkg::BRANCH: begin
                    dec_d.rs1_used  = 1'b1;
                    dec_d.rs2_used  = 1'b1;
                    dec_d.is_branch = 1'b1;
                    dec_d.alu_op    = rv_pkg::SUB;   // compare via flags
                    dec_d.imm       = imm_b;
                end
                rv_pkg::JAL: begin
                    dec_d.rd_we   = 1'b1;        // link written in execute
                    dec_d.is_jump = 1'b1;
                    dec_d.imm     = imm_j;
                end
                default: ;
            endcase
        end
        // unused fields point at x0
        if (!dec_d.rs1_used) dec_d.rs1 = '0;
        if (!dec_d.rs2_used) dec_d.rs2 = '0;
        if (!dec_d.rd_we)    dec_d.rd  = '0;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid_o <= 1'b0;
        end else if (redirect_valid_i) begin
            dec_valid_o <= 1'b0;              // younger than the jump
        end else if (fetch.ready) begin
            dec_valid_o <= fetch.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch.ready && fetch.valid) begin
            dec_data_o <= dec_d;
        end
    end

endmodule

//--- source/fetch_ctrl.sv
`timescale 1ns/1ns

module fetch_ctrl (
    input  logic          clk,
    input  logic          rst_n,
    input  rv_pkg::word_t pc_i,
    output logic          advance_o,
    output logic          imem_valid_o,
    output rv_pkg::word_t imem_addr_o,
    input  logic          imem_ready_i,
    input  rv_pkg::word_t imem_rdata_i,
    input  logic          redirect_valid_i,
    fetch_if.producer     fetch
);

    typedef enum logic {
        FETCH,   // requesting, word goes straight through
        HOLD     // decode stalled, present captured word
    } state_e;

    state_e        state_q;
    state_e        state_d;
    logic          fetch_en_q;    // low in the cycle right after reset
    logic          accept;
    rv_pkg::word_t held_instr_q;
    rv_pkg::word_t held_pc_q;

    assign imem_valid_o = fetch_en_q && (state_q == FETCH);
    assign imem_addr_o  = pc_i;
    assign accept       = imem_valid_o && imem_ready_i;
    assign advance_o    = accept;

    // ------------------------------------------------------------
    // decode side
    // ------------------------------------------------------------
    always_comb begin
        if (state_q == HOLD) begin
            fetch.valid = 1'b1;
            fetch.instr = held_instr_q;
            fetch.pc    = held_pc_q;
        end else begin
            fetch.valid = accept;        // pass through
            fetch.instr = imem_rdata_i;
            fetch.pc    = pc_i;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            FETCH:   if (accept && !fetch.ready) state_d = HOLD;
            HOLD:    if (fetch.ready) state_d = FETCH;
            default: state_d = FETCH;
        endcase
        if (redirect_valid_i) state_d = FETCH;  // held word is stale
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= FETCH;
            fetch_en_q <= 1'b0;
        end else begin
            state_q    <= state_d;
            fetch_en_q <= 1'b1;
        end
    end

    // capture when decode cannot take the word
    always_ff @(posedge clk) begin
        if (accept && !fetch.ready) begin
            held_instr_q <= imem_rdata_i;
            held_pc_q    <= pc_i;
        end
    end

endmodule

//--- source/pc_counter.sv
`timescale 1ns/1ns

module pc_counter (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          advance_i,         // fetch accepted this cycle
    input  logic          redirect_valid_i,
    input  rv_pkg::word_t redirect_pc_i,
    output rv_pkg::word_t pc_o
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_o <= rv_pkg::RESET_PC;
        end else if (redirect_valid_i) begin
            pc_o <= redirect_pc_i;              // wins over a same cycle accept
        end else if (advance_i) begin
            pc_o <= pc_o + rv_pkg::PC_STEP;
        end
    end

endmodule

//--- source/fetch_if.sv
`timescale 1ns/1ns

// fetched word plus its address, fetch -> decode
interface fetch_if;
    rv_pkg::word_t instr;
    rv_pkg::word_t pc;
    logic          valid;
    logic          ready;

    modport producer (output instr, output pc, output valid, input ready);
    modport consumer (input instr, input pc, input valid, output ready);
endinterface

//--- source/rv_pkg.sv
package rv_pkg;

    // ------------------------------------------------------------
    // widths and fixed addresses
    // ------------------------------------------------------------
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    localparam word_t RESET_PC = 32'h0000_0000;  // first fetch after reset
    localparam word_t PC_STEP  = 32'd4;          // bytes per instruction

    // ------------------------------------------------------------
    // encodings
    // ------------------------------------------------------------
    // major opcode, instr[6:2]
    typedef enum logic [4:0] {
        OP_IMM = 5'b00100,
        AUIPC  = 5'b00101,
        OP     = 5'b01100,
        LUI    = 5'b01101,
        BRANCH = 5'b11000,
        JAL    = 5'b11011
    } opcode_e;

    // laid out as {funct7[5], funct3}
    typedef enum logic [3:0] {
        ADD  = 4'b0000,
        SLL  = 4'b0001,
        SLT  = 4'b0010,
        SLTU = 4'b0011,
        XOR  = 4'b0100,
        SRL  = 4'b0101,
        OR   = 4'b0110,
        AND  = 4'b0111,
        SUB  = 4'b1000,
        SRA  = 4'b1101
    } alu_op_e;

    // straight from funct3 of a BRANCH
    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } branch_e;

    typedef struct packed {
        word_t     pc;
        word_t     imm;          // sign extended
        reg_addr_t rs1;
        logic      rs1_used;
        reg_addr_t rs2;
        logic      rs2_used;
        reg_addr_t rd;           // zero when nothing is written
        logic      rd_we;
        alu_op_e   alu_op;
        logic      use_imm;      // operand b is imm
        logic      use_pc;       // operand a is pc
        logic      is_branch;
        logic      is_jump;
        branch_e   branch_cond;
    } decoded_t;

endpackage
